// File: logic/dmem_pkg.sv
package dmem_pkg;

    parameter int ADDR_SIZE   = 32;
    parameter int WORD_SIZE   = 32;
    parameter int REG_SIZE    = 5;
    parameter int LINE_WORDS  = 4;
    parameter int LINE_SIZE   = LINE_WORDS * WORD_SIZE;
    // Byte offset bits inside one line
    parameter int LINE_OFFSET = $clog2(LINE_WORDS) + 2;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_type_e;

    typedef enum logic [1:0] {
        TL_IDLE,
        HAZARD_DC_MISS,
        HAZARD_SB_TROUBLE
    } tl_state_e;

    typedef struct packed {
        logic                 rd;
        logic                 wr;
        logic [ADDR_SIZE-1:0] addr;
        logic [WORD_SIZE-1:0] data;
        memop_type_e          mtype;
        logic                 sign_ext;
        logic [REG_SIZE-1:0]  rd_reg;
    } mem_req_t;

    typedef struct packed {
        logic                 load;
        logic [ADDR_SIZE-1:0] addr;
        memop_type_e          mtype;
        logic                 sign_ext;
        logic [REG_SIZE-1:0]  rd_reg;
        logic                 sb_hit;
        logic [WORD_SIZE-1:0] sb_data;
        logic                 flush;
        logic [ADDR_SIZE-1:0] flush_addr;
        logic [WORD_SIZE-1:0] flush_data;
        memop_type_e          flush_type;
        logic                 flush_line_hit;
    } tl_mem_t;

    typedef struct packed {
        logic                 valid;
        logic [ADDR_SIZE-1:0] addr;
        logic [LINE_SIZE-1:0] line;
    } refill_t;

    typedef struct packed {
        logic                 valid;
        logic [REG_SIZE-1:0]  rd_reg;
        logic [WORD_SIZE-1:0] data;
    } load_result_t;

    // Bytes of a word touched by an access
    function automatic logic [3:0] byte_mask(input logic [1:0] lo, input memop_type_e mtype);
        case (mtype)
            BYTE:    return 4'b0001 << lo;
            HALF:    return 4'b0011 << lo;
            default: return 4'b1111;
        endcase
    endfunction

    // Move store data to its byte lanes
    function automatic logic [WORD_SIZE-1:0] align_data(input logic [1:0] lo,
                                                        input logic [WORD_SIZE-1:0] data);
        return data << {lo, 3'b000};
    endfunction

endpackage

// File: logic/dcache_tag.sv
`timescale 1ns/1ps

module dcache_tag
    import dmem_pkg::*;
#(
    parameter int DCACHE_SETS = 16
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic [ADDR_SIZE-1:0] lookup_addr_i,
    input  logic [ADDR_SIZE-1:0] drain_addr_i,
    input  refill_t              refill_i,
    output logic                 hit_o,
    output logic                 drain_hit_o
);

    localparam int IDX_W = $clog2(DCACHE_SETS);
    localparam int TAG_W = ADDR_SIZE - LINE_OFFSET - IDX_W;

    logic [TAG_W-1:0]       tag_q [DCACHE_SETS];
    logic [DCACHE_SETS-1:0] valid_q;

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] drain_idx;
    logic [IDX_W-1:0] refill_idx;

    assign lookup_idx = lookup_addr_i[LINE_OFFSET +: IDX_W];
    assign drain_idx  = drain_addr_i[LINE_OFFSET +: IDX_W];
    assign refill_idx = refill_i.addr[LINE_OFFSET +: IDX_W];

    assign hit_o = valid_q[lookup_idx] &&
                   (tag_q[lookup_idx] == lookup_addr_i[ADDR_SIZE-1 -: TAG_W]);
    assign drain_hit_o = valid_q[drain_idx] &&
                         (tag_q[drain_idx] == drain_addr_i[ADDR_SIZE-1 -: TAG_W]);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (refill_i.valid) begin
            valid_q[refill_idx] <= 1'b1;
        end
    end

    // Tag storage, written with the refill
    always_ff @(posedge clk_i) begin
        if (refill_i.valid) begin
            tag_q[refill_idx] <= refill_i.addr[ADDR_SIZE-1 -: TAG_W];
        end
    end

endmodule

// File: logic/store_buffer.sv
`timescale 1ns/1ps

module store_buffer
    import dmem_pkg::*;
#(
    parameter int SB_DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 push_i,
    input  logic [ADDR_SIZE-1:0] addr_i,
    input  logic [WORD_SIZE-1:0] data_i,
    input  memop_type_e          mtype_i,
    input  logic                 load_i,
    input  logic                 drain_i,
    output logic                 fwd_hit_o,
    output logic [WORD_SIZE-1:0] fwd_data_o,
    output logic                 trouble_o,
    output logic                 full_o,
    output logic                 head_valid_o,
    output logic [ADDR_SIZE-1:0] head_addr_o,
    output logic [WORD_SIZE-1:0] head_data_o,
    output memop_type_e          head_type_o
);

    localparam int PTR_W = $clog2(SB_DEPTH);
    localparam int CNT_W = $clog2(SB_DEPTH + 1);

    logic [ADDR_SIZE-1:0] addr_q [SB_DEPTH];
    logic [WORD_SIZE-1:0] data_q [SB_DEPTH];
    memop_type_e          type_q [SB_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    logic             do_push;
    logic             do_pop;
    logic             found;
    logic             overlap;
    logic [PTR_W-1:0] found_idx;

    assign full_o       = (count_q == CNT_W'(SB_DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_addr_o  = addr_q[head_q];
    assign head_data_o  = data_q[head_q];
    assign head_type_o  = type_q[head_q];

    assign do_push = push_i && !full_o;
    assign do_pop  = drain_i && head_valid_o;

    // Walk from oldest to newest, so the last match is the newest store
    always_comb begin
        logic [PTR_W-1:0] idx;
        found     = 1'b0;
        overlap   = 1'b0;
        found_idx = head_q;
        for (int i = 0; i < SB_DEPTH; i++) begin
            idx = head_q + PTR_W'(i);
            if (i < int'(count_q) && addr_q[idx][ADDR_SIZE-1:2] == addr_i[ADDR_SIZE-1:2]) begin
                found     = 1'b1;
                found_idx = idx;
                if (|(byte_mask(addr_q[idx][1:0], type_q[idx]) &
                      byte_mask(addr_i[1:0], mtype_i))) begin
                    overlap = 1'b1;
                end
            end
        end
    end

    assign fwd_hit_o  = load_i && found && (type_q[found_idx] == WORD);
    assign fwd_data_o = data_q[found_idx];
    assign trouble_o  = (push_i && full_o) || (load_i && overlap && !fwd_hit_o);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) tail_q <= tail_q + 1'b1;
            if (do_pop) head_q <= head_q + 1'b1;
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            addr_q[tail_q] <= addr_i;
            data_q[tail_q] <= data_i;
            type_q[tail_q] <= mtype_i;
        end
    end

endmodule

// File: logic/tl_stage.sv
`timescale 1ns/1ps

module tl_stage
    import dmem_pkg::*;
#(
    parameter int DCACHE_SETS = 16,
    parameter int SB_DEPTH    = 4
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  mem_req_t             req_i,
    input  refill_t              refill_i,
    output logic                 stall_o,
    output logic                 refill_req_o,
    output logic [ADDR_SIZE-1:0] refill_addr_o,
    output tl_mem_t              tl_mem_o
);

    tl_state_e state_q;
    tl_state_e state_nxt;
    mem_req_t  held_q;
    mem_req_t  cur;

    logic                 tag_hit;
    logic                 drain_hit;
    logic                 sb_push;
    logic                 sb_load;
    logic                 sb_fwd_hit;
    logic [WORD_SIZE-1:0] sb_fwd_data;
    logic                 sb_trouble;
    logic                 sb_head_valid;
    logic [ADDR_SIZE-1:0] sb_head_addr;
    logic [WORD_SIZE-1:0] sb_head_data;
    memop_type_e          sb_head_type;

    logic do_req;
    logic drain;
    logic pass_load;
    logic capture;

    // A stalled request is replayed from the held copy
    assign cur     = (state_q == TL_IDLE) ? req_i : held_q;
    assign stall_o = (state_q != TL_IDLE);

    assign sb_push = cur.wr && (state_q != HAZARD_DC_MISS);
    assign sb_load = cur.rd && (state_q != HAZARD_DC_MISS);

    assign do_req = (state_q == TL_IDLE && (cur.rd || cur.wr)) ||
                    (state_q == HAZARD_SB_TROUBLE && !sb_trouble);

    dcache_tag #(.DCACHE_SETS(DCACHE_SETS)) u_tag (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .lookup_addr_i (cur.addr),
        .drain_addr_i  (sb_head_addr),
        .refill_i      (refill_i),
        .hit_o         (tag_hit),
        .drain_hit_o   (drain_hit)
    );

    store_buffer #(.SB_DEPTH(SB_DEPTH)) u_sb (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_i       (sb_push),
        .addr_i       (cur.addr),
        .data_i       (cur.data),
        .mtype_i      (cur.mtype),
        .load_i       (sb_load),
        .drain_i      (drain),
        .fwd_hit_o    (sb_fwd_hit),
        .fwd_data_o   (sb_fwd_data),
        .trouble_o    (sb_trouble),
        .full_o       (),
        .head_valid_o (sb_head_valid),
        .head_addr_o  (sb_head_addr),
        .head_data_o  (sb_head_data),
        .head_type_o  (sb_head_type)
    );

    always_comb begin
        state_nxt    = state_q;
        drain        = 1'b0;
        pass_load    = 1'b0;
        capture      = 1'b0;
        refill_req_o = 1'b0;
        if (state_q == HAZARD_DC_MISS) begin
            // Refilled line lands in the arrays on this edge
            if (refill_i.valid) begin
                pass_load = 1'b1;
                state_nxt = TL_IDLE;
            end
        end else if (do_req) begin
            state_nxt = TL_IDLE;
            if (sb_trouble) begin
                capture   = 1'b1;
                state_nxt = HAZARD_SB_TROUBLE;
            end else if (cur.rd && (sb_fwd_hit || tag_hit)) begin
                pass_load = 1'b1;
            end else if (cur.rd) begin
                capture      = 1'b1;
                refill_req_o = 1'b1;
                state_nxt    = HAZARD_DC_MISS;
            end
        end else begin
            drain = sb_head_valid;
        end
    end

    assign refill_addr_o = cur.addr;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= TL_IDLE;
            held_q   <= '0;
            tl_mem_o <= '0;
        end else begin
            state_q <= state_nxt;
            if (capture) held_q <= cur;
            tl_mem_o.load           <= pass_load;
            tl_mem_o.addr           <= cur.addr;
            tl_mem_o.mtype          <= cur.mtype;
            tl_mem_o.sign_ext       <= cur.sign_ext;
            tl_mem_o.rd_reg         <= cur.rd_reg;
            tl_mem_o.sb_hit         <= sb_fwd_hit;
            tl_mem_o.sb_data        <= sb_fwd_data;
            tl_mem_o.flush          <= drain;
            tl_mem_o.flush_addr     <= sb_head_addr;
            tl_mem_o.flush_data     <= sb_head_data;
            tl_mem_o.flush_type     <= sb_head_type;
            tl_mem_o.flush_line_hit <= drain_hit;
        end
    end

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import dmem_pkg::*;
#(
    parameter int DCACHE_SETS = 16
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  tl_mem_t              tl_mem_i,
    input  refill_t              refill_i,
    output load_result_t         result_o,
    output logic                 wt_valid_o,
    output logic [ADDR_SIZE-1:0] wt_addr_o,
    output logic [WORD_SIZE-1:0] wt_data_o,
    output memop_type_e          wt_type_o
);

    localparam int IDX_W  = $clog2(DCACHE_SETS);
    localparam int WIDX_W = IDX_W + $clog2(LINE_WORDS);

    logic [WORD_SIZE-1:0] data_q [DCACHE_SETS*LINE_WORDS];

    logic [WIDX_W-1:0]    load_widx;
    logic [WIDX_W-1:0]    flush_widx;
    logic [WIDX_W-1:0]    refill_base;
    logic [3:0]           flush_mask;
    logic [WORD_SIZE-1:0] flush_word;
    logic [WORD_SIZE-1:0] load_word;
    logic [WORD_SIZE-1:0] shifted;
    logic [WORD_SIZE-1:0] extended;

    assign load_widx   = tl_mem_i.addr[2 +: WIDX_W];
    assign flush_widx  = tl_mem_i.flush_addr[2 +: WIDX_W];
    assign refill_base = {refill_i.addr[LINE_OFFSET +: IDX_W], {(WIDX_W-IDX_W){1'b0}}};
    assign flush_mask  = byte_mask(tl_mem_i.flush_addr[1:0], tl_mem_i.flush_type);
    assign flush_word  = align_data(tl_mem_i.flush_addr[1:0], tl_mem_i.flush_data);

    // Write-through leaves straight from the drain slot
    assign wt_valid_o = tl_mem_i.flush;
    assign wt_addr_o  = tl_mem_i.flush_addr;
    assign wt_data_o  = tl_mem_i.flush_data;
    assign wt_type_o  = tl_mem_i.flush_type;

    always_ff @(posedge clk_i) begin
        if (refill_i.valid) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                data_q[refill_base + WIDX_W'(w)] <= refill_i.line[w*WORD_SIZE +: WORD_SIZE];
            end
        end
        if (tl_mem_i.flush && tl_mem_i.flush_line_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (flush_mask[b]) data_q[flush_widx][b*8 +: 8] <= flush_word[b*8 +: 8];
            end
        end
    end

    assign load_word = tl_mem_i.sb_hit ? tl_mem_i.sb_data : data_q[load_widx];
    assign shifted   = load_word >> {tl_mem_i.addr[1:0], 3'b000};

    always_comb begin
        case (tl_mem_i.mtype)
            BYTE:    extended = {{24{tl_mem_i.sign_ext & shifted[7]}}, shifted[7:0]};
            HALF:    extended = {{16{tl_mem_i.sign_ext & shifted[15]}}, shifted[15:0]};
            default: extended = shifted;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else begin
            result_o.valid  <= tl_mem_i.load;
            result_o.rd_reg <= tl_mem_i.rd_reg;
            result_o.data   <= extended;
        end
    end

endmodule

// File: logic/backing_mem.sv
`timescale 1ns/1ps

module backing_mem
    import dmem_pkg::*;
#(
    parameter int MEM_LATENCY = 6,
    parameter int MEM_WORDS   = 1024
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 refill_req_i,
    input  logic [ADDR_SIZE-1:0] refill_addr_i,
    input  logic                 wt_valid_i,
    input  logic [ADDR_SIZE-1:0] wt_addr_i,
    input  logic [WORD_SIZE-1:0] wt_data_i,
    input  memop_type_e          wt_type_i,
    output refill_t              refill_o
);

    localparam int MIDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W  = $clog2(MEM_LATENCY + 1);

    logic [WORD_SIZE-1:0] mem_q [MEM_WORDS];
    logic                 busy_q;
    logic [CNT_W-1:0]     cnt_q;
    logic [ADDR_SIZE-1:0] line_addr_q;

    logic [MIDX_W-1:0]    wt_idx;
    logic [MIDX_W-1:0]    line_base;
    logic [3:0]           wt_mask;
    logic [WORD_SIZE-1:0] wt_word;
    logic [LINE_SIZE-1:0] line;

    assign wt_idx    = wt_addr_i[2 +: MIDX_W];
    assign wt_mask   = byte_mask(wt_addr_i[1:0], wt_type_i);
    assign wt_word   = align_data(wt_addr_i[1:0], wt_data_i);
    assign line_base = {line_addr_q[LINE_OFFSET +: MIDX_W-2], 2'b00};

    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            line[w*WORD_SIZE +: WORD_SIZE] = mem_q[line_base + MIDX_W'(w)];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < MEM_WORDS; i++) mem_q[i] <= '0;
            busy_q      <= 1'b0;
            cnt_q       <= '0;
            line_addr_q <= '0;
            refill_o    <= '0;
        end else begin
            refill_o.valid <= 1'b0;
            if (wt_valid_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (wt_mask[b]) mem_q[wt_idx][b*8 +: 8] <= wt_word[b*8 +: 8];
                end
            end
            if (refill_req_i && !busy_q) begin
                busy_q      <= 1'b1;
                cnt_q       <= CNT_W'(MEM_LATENCY - 1);
                line_addr_q <= refill_addr_i;
            end else if (busy_q) begin
                if (cnt_q == '0) begin
                    busy_q         <= 1'b0;
                    refill_o.valid <= 1'b1;
                    refill_o.addr  <= {line_addr_q[ADDR_SIZE-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}};
                    refill_o.line  <= line;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/dmem_top.sv
`timescale 1ns/1ps

module dmem_top
    import dmem_pkg::*;
#(
    parameter int DCACHE_SETS = 16,
    parameter int SB_DEPTH    = 4,
    parameter int MEM_LATENCY = 6,
    parameter int MEM_WORDS   = 1024
) (
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  mem_req_t     req_i,
    output logic         stall_o,
    output load_result_t result_o
);

    tl_mem_t              tl_mem;
    refill_t              refill;
    logic                 refill_req;
    logic [ADDR_SIZE-1:0] refill_addr;
    logic                 wt_valid;
    logic [ADDR_SIZE-1:0] wt_addr;
    logic [WORD_SIZE-1:0] wt_data;
    memop_type_e          wt_type;

    tl_stage #(
        .DCACHE_SETS (DCACHE_SETS),
        .SB_DEPTH    (SB_DEPTH)
    ) u_tl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .refill_i      (refill),
        .stall_o       (stall_o),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .tl_mem_o      (tl_mem)
    );

    mem_stage #(.DCACHE_SETS(DCACHE_SETS)) u_mem (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .tl_mem_i   (tl_mem),
        .refill_i   (refill),
        .result_o   (result_o),
        .wt_valid_o (wt_valid),
        .wt_addr_o  (wt_addr),
        .wt_data_o  (wt_data),
        .wt_type_o  (wt_type)
    );

    backing_mem #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) u_bmem (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .wt_valid_i    (wt_valid),
        .wt_addr_i     (wt_addr),
        .wt_data_i     (wt_data),
        .wt_type_i     (wt_type),
        .refill_o      (refill)
    );

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// File: dv/dmem_tb.sv
`timescale 1ns/1ps

module dmem_tb
    import dmem_pkg::*;
();

    localparam int SB_DEPTH     = 4;
    localparam int RESET_CYCLES = 16;
    // Summed worst case of all tests including misses
    localparam int CYCLE_LIMIT  = 4000;

    logic         clk;
    logic         arst_n;
    mem_req_t     req;
    logic         stall;
    load_result_t result;

    logic [7:0]   ref_mem [4096];
    load_result_t expected_q [$];
    integer       seed;
    int           cycles;

    tb_clock u_clk (
        .clk_o (clk)
    );

    dmem_top dut_i (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .req_i    (req),
        .stall_o  (stall),
        .result_o (result)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        stop_run($sformatf("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
                           $time, name, got, want));
    endtask

    task automatic check_result(input load_result_t got, input load_result_t want);
        if (got.rd_reg !== want.rd_reg) begin
            report_mismatch("result_o.rd_reg", 32'(got.rd_reg), 32'(want.rd_reg));
        end
        if (got.data !== want.data) begin
            report_mismatch("result_o.data", got.data, want.data);
        end
    endtask

    task automatic check_stall(input logic got, input logic want);
        if (got !== want) begin
            report_mismatch("stall_o", 32'(got), 32'(want));
        end
    endtask

    task automatic check_valid(input logic got, input logic want);
        if (got !== want) begin
            report_mismatch("result_o.valid", 32'(got), 32'(want));
        end
    endtask

    // Little-endian byte model with stores applied in program order
    task automatic model_store(input logic [11:0] a, input memop_type_e mtype,
                               input logic [31:0] data);
        ref_mem[a] = data[7:0];
        if (mtype != BYTE) begin
            ref_mem[a + 12'd1] = data[15:8];
        end
        if (mtype == WORD) begin
            ref_mem[a + 12'd2] = data[23:16];
            ref_mem[a + 12'd3] = data[31:24];
        end
    endtask

    function automatic logic [31:0] model_load(input logic [11:0] a, input memop_type_e mtype,
                                               input logic sign_ext);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_mem[a];
        b1 = ref_mem[a + 12'd1];
        case (mtype)
            BYTE:    return {{24{sign_ext & b0[7]}}, b0};
            HALF:    return {{16{sign_ext & b1[7]}}, b1, b0};
            default: return {ref_mem[a + 12'd3], ref_mem[a + 12'd2], b1, b0};
        endcase
    endfunction

    // Drive at a falling edge, hold while stalled, then go idle
    task automatic issue(input mem_req_t r, output logic stalled);
        load_result_t want;
        if (r.wr) begin
            model_store(r.addr[11:0], r.mtype, r.data);
        end
        if (r.rd) begin
            want.valid  = 1'b1;
            want.rd_reg = r.rd_reg;
            want.data   = model_load(r.addr[11:0], r.mtype, r.sign_ext);
            expected_q.push_back(want);
        end
        req = r;
        @(negedge clk);
        stalled = stall;
        while (stall) begin
            @(negedge clk);
        end
        req = '0;
    endtask

    task automatic do_load(input logic [31:0] addr, input memop_type_e mtype,
                           input logic sign_ext, input logic [4:0] rd_reg,
                           output logic stalled);
        mem_req_t r;
        r          = '0;
        r.rd       = 1'b1;
        r.addr     = addr;
        r.mtype    = mtype;
        r.sign_ext = sign_ext;
        r.rd_reg   = rd_reg;
        issue(r, stalled);
    endtask

    task automatic do_store(input logic [31:0] addr, input memop_type_e mtype,
                            input logic [31:0] data, output logic stalled);
        mem_req_t r;
        r       = '0;
        r.wr    = 1'b1;
        r.addr  = addr;
        r.data  = data;
        r.mtype = mtype;
        issue(r, stalled);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Queue is read on rising edges, away from the monitor
    task automatic wait_results();
        @(posedge clk);
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic test_cold_miss();
        logic s;
        check_stall(stall, 1'b0);
        check_valid(result.valid, 1'b0);
        do_load(32'h010, WORD, 1'b0, 5'd5, s);
        check_stall(s, 1'b1);
        wait_results();
    endtask

    task automatic test_hit_timing();
        logic s;
        do_load(32'h014, WORD, 1'b0, 5'd6, s);
        check_stall(s, 1'b0);
        check_valid(result.valid, 1'b0);
        @(negedge clk);
        check_valid(result.valid, 1'b1);
        wait_results();
    endtask

    task automatic test_forward();
        logic s;
        do_store(32'h018, WORD, 32'hdead_beef, s);
        do_load(32'h018, WORD, 1'b0, 5'd7, s);
        check_stall(s, 1'b0);
        // Let the buffer drain into the cache
        idle_cycles(8);
        do_load(32'h018, WORD, 1'b0, 5'd8, s);
        check_stall(s, 1'b0);
        do_load(32'h01b, BYTE, 1'b1, 5'd9, s);
        wait_results();
    endtask

    task automatic test_byte_half();
        logic s;
        do_store(32'h011, BYTE, 32'h0000_0080, s);
        do_store(32'h012, HALF, 32'h0000_8001, s);
        do_load(32'h011, BYTE, 1'b1, 5'd10, s);
        do_load(32'h011, BYTE, 1'b0, 5'd11, s);
        idle_cycles(6);
        do_load(32'h012, HALF, 1'b1, 5'd12, s);
        do_load(32'h012, HALF, 1'b0, 5'd13, s);
        do_load(32'h010, WORD, 1'b0, 5'd14, s);
        // Store to an uncached line and read it back after a miss
        do_store(32'h033, BYTE, 32'h0000_00f0, s);
        idle_cycles(4);
        do_load(32'h033, BYTE, 1'b1, 5'd15, s);
        do_load(32'h032, HALF, 1'b1, 5'd16, s);
        wait_results();
    endtask

    task automatic test_merge();
        logic s;
        do_store(32'h01c, BYTE, 32'h0000_00a5, s);
        do_load(32'h01c, WORD, 1'b1, 5'd17, s);
        check_stall(s, 1'b1);
        wait_results();
    endtask

    task automatic test_backpressure();
        logic s;
        idle_cycles(8);
        for (int i = 0; i <= SB_DEPTH; i++) begin
            do_store(32'h020 + 32'(4 * i), WORD, 32'h1000_0000 + 32'(i), s);
            check_stall(s, (i == SB_DEPTH));
        end
        wait_results();
    endtask

    // Two aliasing regions, 0x000 and 0x100, share cache sets
    task automatic test_random();
        logic [31:0] rnd;
        logic [31:0] data;
        logic [31:0] addr;
        memop_type_e mtype;
        logic        s;
        for (int i = 0; i < 200; i++) begin
            rnd  = $random(seed);
            data = $random(seed);
            case (rnd[2:1])
                2'd0:    mtype = BYTE;
                2'd1:    mtype = HALF;
                default: mtype = WORD;
            endcase
            addr = {23'd0, rnd[3], 2'b00, rnd[9:4]};
            if (mtype == HALF) begin
                addr[0] = 1'b0;
            end
            if (mtype == WORD) begin
                addr[1:0] = 2'b00;
            end
            if (rnd[0]) begin
                do_load(addr, mtype, rnd[10], rnd[15:11], s);
            end else begin
                do_store(addr, mtype, data, s);
            end
            if (rnd[17]) begin
                idle_cycles(1 + int'(rnd[16]));
            end
        end
        wait_results();
    endtask

    always @(negedge clk) begin
        if (arst_n && result.valid) begin
            if (expected_q.size() == 0) begin
                stop_run("result_o.valid went high with no load outstanding");
            end else begin
                check_result(result, expected_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            stop_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        cycles = 0;
        seed   = 59069;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = 8'h00;
        end
        req    = '0;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        test_cold_miss();
        test_hit_timing();
        test_forward();
        test_byte_half();
        test_merge();
        test_backpressure();
        test_random();

        idle_cycles(4);
        check_stall(stall, 1'b0);
        if (expected_q.size() != 0) begin
            stop_run("loads still waiting for a result at the end of the run");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// File: flist.f
logic/dmem_pkg.sv
logic/dcache_tag.sv
logic/store_buffer.sv
logic/tl_stage.sv
logic/mem_stage.sv
logic/backing_mem.sv
logic/dmem_top.sv
dv/tb_clock.sv
dv/dmem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the data-memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module dmem_tb -o dmem_sim

# A $fatal in the testbench gives a non-zero exit status here
./obj_dir/dmem_sim
